// File: core_cfg_pkg.sv
package core_cfg_pkg;

  //////////////////////////////////////////////////
  // Core sizing
  //////////////////////////////////////////////////

  // Data path width, one machine word
  localparam int unsigned XLEN = 32;

  // Architectural integer registers, x0 included
  localparam int unsigned NUM_REGS = 32;

  // Bits needed to name one register
  localparam int unsigned REG_ADDR_W = $clog2(NUM_REGS);

  // Immediate field width of the I-type format
  localparam int unsigned IMM_W = 12;

  // Shift amount width, low bits of operand B
  localparam int unsigned SHAMT_W = 5;

endpackage

// File: isa_pkg.sv
package isa_pkg;

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////

  // Register-register ALU ops
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  // Register-immediate ALU ops
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  //////////////////////////////////////////////////
  // funct3 and funct7 codes
  //////////////////////////////////////////////////

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Standard funct7 and the SUB/SRA variant
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;

  // ALU operation, 4 bits
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // Register form, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // Immediate form, same opcode and rd slots
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // One instruction word, two views picked by opcode
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

endpackage

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  instr_valid_i,
  input  isa_pkg::instr_u                       instr_i,
  output logic                                  id_valid_o,
  output isa_pkg::alu_op_e                      id_alu_op_o,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0]   id_rs1_o,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0]   id_rs2_o,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0]   id_rd_o,
  output logic [core_cfg_pkg::XLEN-1:0]         id_imm_o,
  output logic                                  id_use_imm_o,
  output logic                                  illegal_o
);

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic isa_pkg::alu_op_e funct3_to_op(input logic [2:0] funct3,
                                                    input logic       alt);
    isa_pkg::alu_op_e op;
    case (funct3)
      isa_pkg::F3_ADD_SUB: op = alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      isa_pkg::F3_SLL:     op = isa_pkg::ALU_SLL;
      isa_pkg::F3_SLT:     op = isa_pkg::ALU_SLT;
      isa_pkg::F3_SLTU:    op = isa_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:     op = isa_pkg::ALU_XOR;
      isa_pkg::F3_SRL_SRA: op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
      isa_pkg::F3_OR:      op = isa_pkg::ALU_OR;
      default:             op = isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  logic                                dec_legal;
  isa_pkg::alu_op_e                    dec_op;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] dec_rs1;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] dec_rs2;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] dec_rd;
  logic [core_cfg_pkg::XLEN-1:0]       dec_imm;
  logic                                dec_use_imm;

  //////////////////////////////////////////////////
  // Combinational decode
  //////////////////////////////////////////////////

  always_comb begin
    dec_legal   = 1'b0;
    dec_op      = isa_pkg::ALU_ADD;
    dec_rs1     = '0;
    dec_rs2     = '0;
    dec_rd      = '0;
    dec_imm     = '0;
    dec_use_imm = 1'b0;
    case (instr_i.r.opcode)
      isa_pkg::OPC_OP: begin
        // Register view
        dec_rs1   = instr_i.r.rs1;
        dec_rs2   = instr_i.r.rs2;
        dec_rd    = instr_i.r.rd;
        dec_op    = funct3_to_op(instr_i.r.funct3, instr_i.r.funct7[5]);
        // Alt funct7 only on SUB and SRA
        dec_legal = (instr_i.r.funct7 == isa_pkg::F7_BASE) ||
                    ((instr_i.r.funct7 == isa_pkg::F7_ALT) &&
                     ((instr_i.r.funct3 == isa_pkg::F3_ADD_SUB) ||
                      (instr_i.r.funct3 == isa_pkg::F3_SRL_SRA)));
      end
      isa_pkg::OPC_OP_IMM: begin
        // Immediate view, rs2 stays zero
        dec_rs1     = instr_i.i.rs1;
        dec_rd      = instr_i.i.rd;
        dec_use_imm = 1'b1;
        dec_imm     = {{(core_cfg_pkg::XLEN - core_cfg_pkg::IMM_W){instr_i.i.imm[11]}},
                       instr_i.i.imm};
        // Only SRAI uses the alt bit, imm[10]
        dec_op      = funct3_to_op(instr_i.i.funct3,
                                   (instr_i.i.funct3 == isa_pkg::F3_SRL_SRA) &&
                                   instr_i.i.imm[10]);
        case (instr_i.i.funct3)
          isa_pkg::F3_SLL:     dec_legal = (instr_i.i.imm[11:5] == isa_pkg::F7_BASE);
          isa_pkg::F3_SRL_SRA: dec_legal = (instr_i.i.imm[11:5] == isa_pkg::F7_BASE) ||
                                           (instr_i.i.imm[11:5] == isa_pkg::F7_ALT);
          default:             dec_legal = 1'b1;
        endcase
      end
      default: dec_legal = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Decode registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_valid_o   <= 1'b0;
      illegal_o    <= 1'b0;
      id_alu_op_o  <= isa_pkg::ALU_ADD;
      id_rs1_o     <= '0;
      id_rs2_o     <= '0;
      id_rd_o      <= '0;
      id_imm_o     <= '0;
      id_use_imm_o <= 1'b0;
    end else begin
      id_valid_o <= instr_valid_i && dec_legal;
      // One-cycle pulse, nothing goes downstream
      illegal_o  <= instr_valid_i && !dec_legal;
      if (instr_valid_i && dec_legal) begin
        id_alu_op_o  <= dec_op;
        id_rs1_o     <= dec_rs1;
        id_rs2_o     <= dec_rs2;
        id_rd_o      <= dec_rd;
        id_imm_o     <= dec_imm;
        id_use_imm_o <= dec_use_imm;
      end
    end
  end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Read port A
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr_a_i,
  output logic [core_cfg_pkg::XLEN-1:0]       rdata_a_o,
  // Read port B
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [core_cfg_pkg::XLEN-1:0]       rdata_b_o,
  // Write port
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [core_cfg_pkg::XLEN-1:0]       wdata_i,
  input  logic                                we_i
);

  // Storage for x1 and up
  logic [core_cfg_pkg::NUM_REGS-1:1][core_cfg_pkg::XLEN-1:0] rf_q;
  // Full view with x0 in slot 0
  logic [core_cfg_pkg::NUM_REGS-1:0][core_cfg_pkg::XLEN-1:0] rf_all;
  // One-hot write enables
  logic [core_cfg_pkg::NUM_REGS-1:1]                         we_dec;

  //////////////////////////////////////////////////
  // Write address decode
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 1; i < core_cfg_pkg::NUM_REGS; i++) begin
      we_dec[i] = we_i && (waddr_i == core_cfg_pkg::REG_ADDR_W'(i));
    end
  end

  // No enable for x0, writes there vanish
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rf_q <= '0;
    end else begin
      for (int r = 1; r < core_cfg_pkg::NUM_REGS; r++) begin
        if (we_dec[r]) begin
          rf_q[r] <= wdata_i;
        end
      end
    end
  end

  // x0 hardwired
  assign rf_all[0]                          = '0;
  assign rf_all[core_cfg_pkg::NUM_REGS-1:1] = rf_q;

  // Combinational reads
  assign rdata_a_o = rf_all[raddr_a_i];
  assign rdata_b_o = rf_all[raddr_b_i];

endmodule

// File: alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // From decode
  input  logic                                id_valid_i,
  input  isa_pkg::alu_op_e                    id_alu_op_i,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rs1_i,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rs2_i,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rd_i,
  input  logic [core_cfg_pkg::XLEN-1:0]       id_imm_i,
  input  logic                                id_use_imm_i,
  // Register file reads
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr_b_o,
  input  logic [core_cfg_pkg::XLEN-1:0]       rdata_a_i,
  input  logic [core_cfg_pkg::XLEN-1:0]       rdata_b_i,
  // Result register, also the writeback
  output logic                                wb_valid_o,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [core_cfg_pkg::XLEN-1:0]       wb_data_o
);

  logic                                fwd_a;
  logic                                fwd_b;
  logic [core_cfg_pkg::XLEN-1:0]       rs1_val;
  logic [core_cfg_pkg::XLEN-1:0]       rs2_val;
  logic [core_cfg_pkg::XLEN-1:0]       op_a;
  logic [core_cfg_pkg::XLEN-1:0]       op_b;
  logic [core_cfg_pkg::SHAMT_W-1:0]    shamt;
  logic [core_cfg_pkg::XLEN-1:0]       alu_res;

  assign raddr_a_o = id_rs1_i;
  assign raddr_b_o = id_rs2_i;

  //////////////////////////////////////////////////
  // Operand bypass
  //////////////////////////////////////////////////

  // Pending result not yet in the register file
  // x0 never forwarded
  assign fwd_a = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == id_rs1_i);
  assign fwd_b = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == id_rs2_i);

  assign rs1_val = fwd_a ? wb_data_o : rdata_a_i;
  assign rs2_val = fwd_b ? wb_data_o : rdata_b_i;

  assign op_a  = rs1_val;
  // Immediate replaces rs2 on I-type
  assign op_b  = id_use_imm_i ? id_imm_i : rs2_val;
  assign shamt = op_b[core_cfg_pkg::SHAMT_W-1:0];

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  always_comb begin
    case (id_alu_op_i)
      isa_pkg::ALU_ADD:  alu_res = op_a + op_b;
      isa_pkg::ALU_SUB:  alu_res = op_a - op_b;
      isa_pkg::ALU_AND:  alu_res = op_a & op_b;
      isa_pkg::ALU_OR:   alu_res = op_a | op_b;
      isa_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      isa_pkg::ALU_SLL:  alu_res = op_a << shamt;
      isa_pkg::ALU_SRL:  alu_res = op_a >> shamt;
      // Arithmetic shift keeps the sign
      isa_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
      // Compares give 0 or 1
      isa_pkg::ALU_SLT:  alu_res = {{(core_cfg_pkg::XLEN-1){1'b0}},
                                    ($signed(op_a) < $signed(op_b))};
      isa_pkg::ALU_SLTU: alu_res = {{(core_cfg_pkg::XLEN-1){1'b0}}, (op_a < op_b)};
      default:           alu_res = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_o <= 1'b0;
      wb_rd_o    <= '0;
      wb_data_o  <= '0;
    end else begin
      wb_valid_o <= id_valid_i;
      // Hold last result while idle
      if (id_valid_i) begin
        wb_rd_o   <= id_rd_i;
        wb_data_o <= alu_res;
      end
    end
  end

endmodule

// File: int_pipeline_top.sv
`timescale 1ns/1ps

module int_pipeline_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                instr_valid_i,
  input  logic [core_cfg_pkg::XLEN-1:0]       instr_i,
  output logic                                illegal_o,
  output logic                                wb_valid_o,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [core_cfg_pkg::XLEN-1:0]       wb_data_o
);

  // Decode to execute
  logic                                id_valid;
  isa_pkg::alu_op_e                    id_alu_op;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rs1;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rs2;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rd;
  logic [core_cfg_pkg::XLEN-1:0]       id_imm;
  logic                                id_use_imm;

  // Register file read ports
  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr_a;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr_b;
  logic [core_cfg_pkg::XLEN-1:0]       rdata_a;
  logic [core_cfg_pkg::XLEN-1:0]       rdata_b;

  instr_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .id_valid_o    (id_valid),
    .id_alu_op_o   (id_alu_op),
    .id_rs1_o      (id_rs1),
    .id_rs2_o      (id_rs2),
    .id_rd_o       (id_rd),
    .id_imm_o      (id_imm),
    .id_use_imm_o  (id_use_imm),
    .illegal_o     (illegal_o)
  );

  alu_stage u_alu_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .id_valid_i   (id_valid),
    .id_alu_op_i  (id_alu_op),
    .id_rs1_i     (id_rs1),
    .id_rs2_i     (id_rs2),
    .id_rd_i      (id_rd),
    .id_imm_i     (id_imm),
    .id_use_imm_i (id_use_imm),
    .raddr_a_o    (raddr_a),
    .raddr_b_o    (raddr_b),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

  // Result register feeds the write port directly
  register_file u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .rdata_a_o (rdata_a),
    .raddr_b_i (raddr_b),
    .rdata_b_o (rdata_b),
    .waddr_i   (wb_rd_o),
    .wdata_i   (wb_data_o),
    .we_i      (wb_valid_o)
  );

endmodule

// File: int_pipeline_sva.sv
`timescale 1ns/1ps

module int_pipeline_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_valid_i,
  input logic illegal_o,
  input logic wb_valid_o
);

  //////////////////////////////////////////////////
  // Writeback timing
  //////////////////////////////////////////////////

  // Legal strobe gives a result two edges later
  a_wb_after_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(instr_valid_i, 2) && !$past(illegal_o)) |-> wb_valid_o)
    else $error("writeback missing two cycles after a legal strobe");

  // No result without a strobe
  a_wb_has_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_o |-> $past(instr_valid_i, 2))
    else $error("writeback without a strobe two cycles earlier");

  //////////////////////////////////////////////////
  // Illegal pulse and reset
  //////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> (!illegal_o && !wb_valid_o))
    else $error("output valid during reset");

  // Rejected word never reaches writeback
  a_illegal_no_wb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_o |=> !wb_valid_o)
    else $error("writeback after an illegal pulse");

endmodule

bind int_pipeline_top int_pipeline_sva u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .instr_valid_i (instr_valid_i),
  .illegal_o     (illegal_o),
  .wb_valid_o    (wb_valid_o)
);

// File: tb_int_pipeline.sv
`timescale 1ns/1ps

module tb_int_pipeline;

  localparam int N_INSTR = 2000;
  // Ten cycles per instruction covers the longest idle gaps, plus reset and drain
  localparam int TIMEOUT_CYCLES = (N_INSTR + 32) * 10 + 100;

  logic                                clk_i;
  logic                                rst_ni;
  logic                                instr_valid_i;
  logic [core_cfg_pkg::XLEN-1:0]       instr_i;
  logic                                illegal_o;
  logic                                wb_valid_o;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd_o;
  logic [core_cfg_pkg::XLEN-1:0]       wb_data_o;

  // Reference register array, x0 stays zero
  logic [core_cfg_pkg::XLEN-1:0]       model_regs [core_cfg_pkg::NUM_REGS];
  // Expected writebacks in program order
  logic [core_cfg_pkg::REG_ADDR_W-1:0] exp_rd_q [$];
  logic [core_cfg_pkg::XLEN-1:0]       exp_data_q [$];
  int                                  exp_due_q [$];
  // Cycles in which illegal_o must pulse
  int                                  ill_due_q [$];
  // Falling edge count
  int                                  cycle;

  int_pipeline_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .illegal_o     (illegal_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Outputs sampled at the falling edge, half a cycle after they settle
  task automatic check_outputs();
    logic exp_wb;
    logic exp_ill;
    exp_wb  = (exp_due_q.size() > 0) && (exp_due_q[0] == cycle);
    exp_ill = (ill_due_q.size() > 0) && (ill_due_q[0] == cycle);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'(exp_wb));
    check_value("illegal_o", 32'(illegal_o), 32'(exp_ill));
    if (exp_wb) begin
      check_value("wb_rd_o", 32'(wb_rd_o), 32'(exp_rd_q[0]));
      check_value("wb_data_o", wb_data_o, exp_data_q[0]);
      void'(exp_rd_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(exp_due_q.pop_front());
    end
    if (exp_ill) begin
      void'(ill_due_q.pop_front());
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Executes one word in program order at strobe time
  task automatic apply_model(input logic [31:0] word);
    isa_pkg::instr_u iw;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     res;
    logic [6:0]      f7;
    logic [4:0]      sh;
    logic            legal;
    iw    = word;
    legal = 1'b0;
    f7    = 7'h00;
    a     = model_regs[iw.r.rs1];
    b     = '0;
    if (iw.r.opcode == isa_pkg::OPC_OP) begin
      b     = model_regs[iw.r.rs2];
      f7    = iw.r.funct7;
      legal = (f7 == 7'h00) ||
              ((f7 == 7'h20) && (iw.r.funct3 inside {isa_pkg::F3_ADD_SUB, isa_pkg::F3_SRL_SRA}));
    end else if (iw.i.opcode == isa_pkg::OPC_OP_IMM) begin
      b = {{20{iw.i.imm[11]}}, iw.i.imm};
      // Upper immediate bits only act as funct7 on shifts
      if (iw.i.funct3 inside {isa_pkg::F3_SLL, isa_pkg::F3_SRL_SRA}) begin
        f7 = iw.i.imm[11:5];
      end
      legal = (f7 == 7'h00) || ((f7 == 7'h20) && (iw.i.funct3 == isa_pkg::F3_SRL_SRA));
    end
    sh = b[4:0];
    case (iw.r.funct3)
      isa_pkg::F3_ADD_SUB: res = f7[5] ? a - b : a + b;
      isa_pkg::F3_SLL:     res = a << sh;
      isa_pkg::F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
      isa_pkg::F3_XOR:     res = a ^ b;
      isa_pkg::F3_SRL_SRA: res = f7[5] ? $unsigned($signed(a) >>> sh) : a >> sh;
      isa_pkg::F3_OR:      res = a | b;
      default:             res = a & b;
    endcase
    if (legal) begin
      if (iw.r.rd != 5'd0) begin
        model_regs[iw.r.rd] = res;
      end
      exp_rd_q.push_back(iw.r.rd);
      exp_data_q.push_back(res);
      exp_due_q.push_back(cycle + 2);
    end else begin
      ill_due_q.push_back(cycle + 1);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Registers x0..x7 only, so dependences are frequent
  function automatic logic [31:0] random_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [31:0] w;
    int          kind;
    rd   = 5'($urandom_range(7));
    rs1  = 5'($urandom_range(7));
    rs2  = 5'($urandom_range(7));
    f3   = 3'($urandom_range(7));
    imm  = 12'($urandom);
    kind = int'($urandom_range(99));
    if (kind < 4) begin
      // Branch opcode, not supported
      w      = $urandom;
      w[6:0] = 7'b1100011;
    end else if (kind < 7) begin
      // Multiply-style funct7
      w = {7'h01, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
    end else if (kind < 10) begin
      // SLLI with alt funct7
      w = {7'h20, imm[4:0], rs1, isa_pkg::F3_SLL, rd, isa_pkg::OPC_OP_IMM};
    end else if (kind < 55) begin
      f7 = ((f3 inside {isa_pkg::F3_ADD_SUB, isa_pkg::F3_SRL_SRA}) &&
            ($urandom_range(1) != 0)) ? 7'h20 : 7'h00;
      w  = {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
    end else begin
      if (f3 == isa_pkg::F3_SLL) begin
        imm[11:5] = 7'h00;
      end else if (f3 == isa_pkg::F3_SRL_SRA) begin
        imm[11:5] = ($urandom_range(1) != 0) ? 7'h20 : 7'h00;
      end
      w = {imm, rs1, f3, rd, isa_pkg::OPC_OP_IMM};
    end
    return w;
  endfunction

  // Check last cycle's outputs, then drive the next input
  task automatic drive_cycle(input logic valid, input logic [31:0] word);
    @(negedge clk_i);
    cycle++;
    check_outputs();
    instr_valid_i = valid;
    instr_i       = word;
    if (valid) begin
      apply_model(word);
    end
  endtask

  initial begin
    void'($urandom(33));
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    cycle         = 0;
    for (int r = 0; r < core_cfg_pkg::NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    // Outputs stay low while reset is held
    repeat (4) drive_cycle(1'b0, '0);
    check_value("wb_rd_o", 32'(wb_rd_o), 32'h0);
    check_value("wb_data_o", wb_data_o, 32'h0);
    rst_ni = 1'b1;
    // ADD x0 reads every register back
    for (int r = 0; r < core_cfg_pkg::NUM_REGS; r++) begin
      drive_cycle(1'b1, {isa_pkg::F7_BASE, 5'(r), 5'(r), isa_pkg::F3_ADD_SUB, 5'd0,
                         isa_pkg::OPC_OP});
    end
    for (int n = 0; n < N_INSTR; n++) begin
      drive_cycle(1'b1, random_instr());
      // Occasional idle gap with junk on the bus
      if ($urandom_range(3) == 0) begin
        repeat ($urandom_range(3, 1)) drive_cycle(1'b0, $urandom);
      end
    end
    // Drain the pipeline
    repeat (4) drive_cycle(1'b0, '0);
    if ((exp_rd_q.size() == 0) && (ill_due_q.size() == 0)) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Expected results still pending at the end of the run");
      $display("Test FAILED");
      $fatal(1, "pending expectations");
    end
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

endmodule

// File: src.f
core_cfg_pkg.sv
isa_pkg.sv
instr_decoder.sv
register_file.sv
alu_stage.sv
int_pipeline_top.sv
int_pipeline_sva.sv
tb_int_pipeline.sv

// File: Makefile
TOP  := tb_int_pipeline
BIN  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): src.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o V$(TOP)

# The log decides pass or fail
run: $(BIN)
	-./$(BIN) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
